/* rv_pipe_pkg.sv */
package rv_pipe_pkg;

    localparam int XLEN               = 64;
    localparam int NUM_REGS           = 32;
    localparam int REG_ADDR_W         = $clog2(NUM_REGS);
    localparam int WB_SEL_W           = XLEN / 8;
    localparam int BUS_TIMEOUT_CYCLES = 16;
    localparam int BUS_CNT_W          = $clog2(BUS_TIMEOUT_CYCLES + 1);

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0]           instr_t;
    typedef logic [6:0]            opcode_t;
    typedef logic [2:0]            alu_op_t;
    typedef logic [WB_SEL_W-1:0]   wb_sel_t;
    typedef logic [BUS_CNT_W-1:0]  bus_count_t;

    // RV64I major opcodes
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_DWORD   = 3'b011; // LD / SD width

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_WAIT,
        BUS_ERROR
    } bus_state_e;

endpackage

/* pipe_ifs.sv */
`timescale 1ns/100ps

interface issue_if;
    import rv_pipe_pkg::*;

    logic      valid;
    alu_op_t   alu_op;
    xlen_t     op_a;
    xlen_t     op_b;
    reg_addr_t rd;
    logic      writes_rd;
    logic      is_load;
    logic      is_store;
    xlen_t     store_data;

    modport producer (output valid, alu_op, op_a, op_b, rd, writes_rd,
                      is_load, is_store, store_data);
    modport consumer (input valid, alu_op, op_a, op_b, rd, writes_rd,
                      is_load, is_store, store_data);
endinterface

interface memreq_if;
    import rv_pipe_pkg::*;

    logic      valid;
    logic      is_load;
    logic      is_store;
    reg_addr_t rd;
    logic      writes_rd;
    xlen_t     addr_or_result; // address for LD/SD, else ALU result
    xlen_t     store_data;

    modport producer (output valid, is_load, is_store, rd, writes_rd,
                      addr_or_result, store_data);
    modport consumer (input valid, is_load, is_store, rd, writes_rd,
                      addr_or_result, store_data);
endinterface

interface result_if;
    import rv_pipe_pkg::*;

    logic      valid;        // data usable for forwarding
    logic      pending_load; // rd will be written by a load not yet done
    reg_addr_t rd;
    xlen_t     data;

    modport producer (output valid, pending_load, rd, data);
    modport consumer (input valid, pending_load, rd, data);
endinterface

/* reg_file.sv */
`timescale 1ns/100ps

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_pipe_pkg::reg_addr_t rs1_addr,
    input  rv_pipe_pkg::reg_addr_t rs2_addr,
    output rv_pipe_pkg::xlen_t     rs1_data,
    output rv_pipe_pkg::xlen_t     rs2_data,
    result_if.consumer             wb
);
    import rv_pipe_pkg::*;

    xlen_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && (wb.rd != '0)) begin // x0 never written
            regs[wb.rd] <= wb.data;
        end
    end

    // same-cycle write is covered by the wb forward path
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

/* id_stage.sv */
`timescale 1ns/100ps

module id_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  rv_pipe_pkg::instr_t instr,
    output logic                instr_ready,
    input  logic                stall,
    result_if.consumer          ex_fwd,
    result_if.consumer          mem_fwd,
    result_if.consumer          wb_fwd,
    issue_if.producer           issue
);
    import rv_pipe_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      rf_rs1;
    xlen_t      rf_rs2;
    xlen_t      rs1_val;
    xlen_t      rs2_val;
    alu_op_t    dec_alu_op;
    logic       dec_ok;
    logic       is_op;
    logic       is_op_imm;
    logic       is_load;
    logic       is_store;
    logic       uses_rs2;
    logic       hold;

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .rs1_data (rf_rs1),
        .rs2_data (rf_rs2),
        .wb       (wb_fwd)
    );

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];
    assign imm_i  = {{(XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s  = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};

    assign is_op     = (opcode == OPC_OP);
    assign is_op_imm = (opcode == OPC_OP_IMM);
    assign is_load   = (opcode == OPC_LOAD);
    assign is_store  = (opcode == OPC_STORE);
    assign uses_rs2  = is_op || is_store;

    always_comb begin
        dec_alu_op = ALU_ADD; // loads and stores add base + offset
        dec_ok     = 1'b0;
        case (opcode)
            OPC_OP: begin
                dec_ok = (funct7 == F7_BASE);
                case (funct3)
                    F3_ADD_SUB: begin
                        if (funct7 == F7_SUB) begin
                            dec_alu_op = ALU_SUB;
                            dec_ok     = 1'b1;
                        end
                    end
                    F3_XOR:  dec_alu_op = ALU_XOR;
                    F3_OR:   dec_alu_op = ALU_OR;
                    F3_AND:  dec_alu_op = ALU_AND;
                    default: dec_ok = 1'b0;
                endcase
            end
            OPC_OP_IMM:          dec_ok = (funct3 == F3_ADD_SUB); // ADDI only
            OPC_LOAD, OPC_STORE: dec_ok = (funct3 == F3_DWORD);
            default:             dec_ok = 1'b0;
        endcase
    end

    // youngest writer wins: EX, then MEM, then WB, then regfile
    function automatic xlen_t fwd_operand(input reg_addr_t rs, input xlen_t rf_val);
        xlen_t val;
        if (rs == '0) begin
            val = '0;
        end else if (ex_fwd.valid && (ex_fwd.rd == rs)) begin
            val = ex_fwd.data;
        end else if (mem_fwd.valid && (mem_fwd.rd == rs)) begin
            val = mem_fwd.data;
        end else if (wb_fwd.valid && (wb_fwd.rd == rs)) begin
            val = wb_fwd.data;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    function automatic logic load_hit(input reg_addr_t rs);
        return (rs != '0) &&
               ((ex_fwd.pending_load && (ex_fwd.rd == rs)) ||
                (mem_fwd.pending_load && (mem_fwd.rd == rs)));
    endfunction

    assign rs1_val = fwd_operand(rs1, rf_rs1);
    assign rs2_val = fwd_operand(rs2, rf_rs2);

    assign hold        = instr_valid && dec_ok && (load_hit(rs1) || (uses_rs2 && load_hit(rs2)));
    assign instr_ready = !stall && !hold;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue.valid <= 1'b0;
        end else if (!stall) begin
            issue.valid <= instr_valid && dec_ok && !hold; // bubble on hold
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            issue.alu_op     <= dec_alu_op;
            issue.op_a       <= rs1_val;
            issue.op_b       <= is_op ? rs2_val : (is_store ? imm_s : imm_i);
            issue.rd         <= rd;
            issue.writes_rd  <= (is_op || is_op_imm || is_load) && (rd != '0);
            issue.is_load    <= is_load;
            issue.is_store   <= is_store;
            issue.store_data <= rs2_val;
        end
    end

endmodule

/* alu_stage.sv */
`timescale 1ns/100ps

module alu_stage (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall,
    issue_if.consumer  issue,
    result_if.producer ex_fwd,
    memreq_if.producer memreq
);
    import rv_pipe_pkg::*;

    xlen_t alu_res;

    always_comb begin
        case (issue.alu_op)
            ALU_ADD: alu_res = issue.op_a + issue.op_b;
            ALU_SUB: alu_res = issue.op_a - issue.op_b;
            ALU_AND: alu_res = issue.op_a & issue.op_b;
            ALU_OR:  alu_res = issue.op_a | issue.op_b;
            ALU_XOR: alu_res = issue.op_a ^ issue.op_b;
            default: alu_res = '0;
        endcase
    end

    // a load result in EX is only an address, so it is not forwarded
    assign ex_fwd.valid        = issue.valid && issue.writes_rd && !issue.is_load;
    assign ex_fwd.pending_load = issue.valid && issue.writes_rd && issue.is_load;
    assign ex_fwd.rd           = issue.rd;
    assign ex_fwd.data         = alu_res;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            memreq.valid <= 1'b0;
        end else if (!stall) begin
            memreq.valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            memreq.is_load        <= issue.is_load;
            memreq.is_store       <= issue.is_store;
            memreq.rd             <= issue.rd;
            memreq.writes_rd      <= issue.writes_rd;
            memreq.addr_or_result <= alu_res;
            memreq.store_data     <= issue.store_data;
        end
    end

endmodule

/* mem_bus_fsm.sv */
`timescale 1ns/100ps

module mem_bus_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    memreq_if.consumer           memreq,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output rv_pipe_pkg::xlen_t   wb_adr,
    output rv_pipe_pkg::wb_sel_t wb_sel,
    output rv_pipe_pkg::xlen_t   wb_dat_o,
    input  rv_pipe_pkg::xlen_t   wb_dat_i,
    input  logic                 wb_ack,
    output logic                 stall,
    output logic                 timer_run,
    input  logic                 timeout,
    output logic                 bus_error,
    result_if.producer           mem_fwd,
    result_if.producer           wb_fwd
);
    import rv_pipe_pkg::*;

    bus_state_e state;
    bus_state_e state_next;
    logic       mem_access;
    logic       acked;
    logic       aborted;

    assign mem_access = memreq.valid && (memreq.is_load || memreq.is_store);
    assign acked      = (state == BUS_WAIT) && wb_ack;
    assign aborted    = (state == BUS_WAIT) && !wb_ack && timeout; // ack wins a tie
    assign stall      = mem_access && !(acked || aborted);

    always_comb begin
        state_next = state;
        case (state)
            BUS_IDLE: begin
                if (mem_access) begin
                    state_next = BUS_WAIT;
                end
            end
            BUS_WAIT: begin
                if (acked) begin
                    state_next = BUS_IDLE;
                end else if (aborted) begin
                    state_next = BUS_ERROR;
                end
            end
            BUS_ERROR: state_next = BUS_IDLE; // one idle slot after an abort
            default:   state_next = BUS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= BUS_IDLE;
            bus_error <= 1'b0;
        end else begin
            state <= state_next;
            if (aborted) begin
                bus_error <= 1'b1; // sticky until reset
            end
        end
    end

    // memreq holds under stall, so adr/dat/we stay put until ack
    assign wb_cyc    = (state == BUS_WAIT);
    assign wb_stb    = wb_cyc;
    assign wb_we     = memreq.is_store;
    assign wb_adr    = memreq.addr_or_result;
    assign wb_dat_o  = memreq.store_data;
    assign wb_sel    = '1;
    assign timer_run = (state == BUS_WAIT);

    assign mem_fwd.valid        = memreq.valid && memreq.writes_rd && !memreq.is_load;
    assign mem_fwd.pending_load = memreq.valid && memreq.writes_rd && memreq.is_load;
    assign mem_fwd.rd           = memreq.rd;
    assign mem_fwd.data         = memreq.addr_or_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_fwd.valid <= 1'b0;
        end else begin
            wb_fwd.valid <= memreq.valid && memreq.writes_rd && !stall;
        end
    end

    always_ff @(posedge clk) begin
        wb_fwd.rd <= memreq.rd;
        if (memreq.is_load) begin
            wb_fwd.data <= acked ? wb_dat_i : '0; // aborted load reads zero
        end else begin
            wb_fwd.data <= memreq.addr_or_result;
        end
    end

    assign wb_fwd.pending_load = 1'b0;

endmodule

/* bus_timer.sv */
`timescale 1ns/100ps

module bus_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    output logic timeout
);
    import rv_pipe_pkg::*;

    bus_count_t count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!run) begin
            count <= '0;
        end else if (!timeout) begin
            count <= count + 1'b1; // saturates at the limit
        end
    end

    assign timeout = run && (count == bus_count_t'(BUS_TIMEOUT_CYCLES));

endmodule

/* rv_pipe_top.sv */
`timescale 1ns/100ps

module rv_pipe_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 instr_valid,
    input  rv_pipe_pkg::instr_t  instr,
    output logic                 instr_ready,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output rv_pipe_pkg::xlen_t   wb_adr,
    output rv_pipe_pkg::wb_sel_t wb_sel,
    output rv_pipe_pkg::xlen_t   wb_dat_o,
    input  rv_pipe_pkg::xlen_t   wb_dat_i,
    input  logic                 wb_ack,
    output logic                 bus_error
);

    logic stall;
    logic timer_run;
    logic timeout;

    issue_if  u_issue_if ();
    memreq_if u_memreq_if ();
    result_if u_ex_fwd ();
    result_if u_mem_fwd ();
    result_if u_wb_fwd ();

    id_stage u_id_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .stall       (stall),
        .ex_fwd      (u_ex_fwd),
        .mem_fwd     (u_mem_fwd),
        .wb_fwd      (u_wb_fwd),
        .issue       (u_issue_if)
    );

    alu_stage u_alu_stage (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall),
        .issue  (u_issue_if),
        .ex_fwd (u_ex_fwd),
        .memreq (u_memreq_if)
    );

    mem_bus_fsm u_mem_bus_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .memreq    (u_memreq_if),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_sel    (wb_sel),
        .wb_dat_o  (wb_dat_o),
        .wb_dat_i  (wb_dat_i),
        .wb_ack    (wb_ack),
        .stall     (stall),
        .timer_run (timer_run),
        .timeout   (timeout),
        .bus_error (bus_error),
        .mem_fwd   (u_mem_fwd),
        .wb_fwd    (u_wb_fwd)
    );

    bus_timer u_bus_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .run     (timer_run),
        .timeout (timeout)
    );

endmodule

/* rv_pipe_asserts.sv */
`timescale 1ns/100ps

module rv_pipe_asserts (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 instr_ready,
    input logic                 wb_cyc,
    input logic                 wb_stb,
    input logic                 wb_we,
    input rv_pipe_pkg::xlen_t   wb_adr,
    input rv_pipe_pkg::wb_sel_t wb_sel,
    input rv_pipe_pkg::xlen_t   wb_dat_o,
    input logic                 wb_ack,
    input logic                 bus_error
);
    import rv_pipe_pkg::*;

    localparam int CYC_LIMIT   = BUS_TIMEOUT_CYCLES + 2;
    localparam int READY_LIMIT = 40;

    logic [7:0] cyc_len;
    logic [7:0] ready_low_len;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc_len       <= '0;
            ready_low_len <= '0;
        end else begin
            cyc_len       <= wb_cyc ? cyc_len + 8'd1 : 8'd0;
            ready_low_len <= instr_ready ? 8'd0 : ready_low_len + 8'd1;
        end
    end

    a_cyc_eq_stb: assert property (@(posedge clk) disable iff (!rst_n) wb_cyc == wb_stb)
        else $error("wb_cyc and wb_stb differ");
    a_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> (!wb_stb ||
            ($stable(wb_adr) && $stable(wb_dat_o) && $stable(wb_we))))
        else $error("bus request changed before ack");
    a_drop_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && wb_ack) |=> !wb_stb)
        else $error("stb still high the cycle after ack");
    a_sel: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> (wb_sel == '1))
        else $error("wb_sel not all ones");
    a_reset: assert property (@(posedge clk) !rst_n |-> (!wb_cyc && !wb_stb && !bus_error))
        else $error("bus outputs active in reset");
    a_err_sticky: assert property (@(posedge clk) disable iff (!rst_n) bus_error |=> bus_error)
        else $error("bus_error dropped without reset");
    a_cyc_bound: assert property (@(posedge clk) disable iff (!rst_n)
        int'(cyc_len) <= CYC_LIMIT)
        else $error("bus cycle not closed within the timeout bound");
    a_ready_back: assert property (@(posedge clk) disable iff (!rst_n)
        int'(ready_low_len) <= READY_LIMIT)
        else $error("instr_ready stayed low too long");

endmodule

bind rv_pipe_top rv_pipe_asserts u_rv_pipe_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_ready (instr_ready),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_sel      (wb_sel),
    .wb_dat_o    (wb_dat_o),
    .wb_ack      (wb_ack),
    .bus_error   (bus_error)
);

/* tb_rv_pipe.sv */
`timescale 1ns/100ps

module tb_rv_pipe;
    import rv_pipe_pkg::*;

    localparam int K_ADD  = 0;
    localparam int K_SUB  = 1;
    localparam int K_AND  = 2;
    localparam int K_OR   = 3;
    localparam int K_XOR  = 4;
    localparam int K_ADDI = 5;
    localparam int K_LD   = 6;
    localparam int K_SD   = 7;

    logic       clk = 1'b0;
    logic       rst_n = 1'b0;
    logic       instr_valid = 1'b0;
    instr_t     instr = '0;
    logic       instr_ready;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    xlen_t      wb_adr;
    wb_sel_t    wb_sel;
    xlen_t      wb_dat_o;
    xlen_t      wb_dat_i = '0;
    logic       wb_ack = 1'b0;
    logic       bus_error;

    xlen_t      mem [64];       // slave memory
    xlen_t      model_mem [64]; // memory as seen in program order
    xlen_t      mregs [NUM_REGS];
    xlen_t      exp_adr [$];
    xlen_t      exp_dat [$];
    logic       ack_enable = 1'b1;
    logic       busy = 1'b0;
    int         wait_left = 0;
    int         errors = 0;
    int         tests = 0;
    int         checks = 0;
    logic       hung = 1'b0;
    string      test_name = "reset";

    rv_pipe_top u_rv_pipe_top (.*);

    initial begin
        forever #5 clk = ~clk;
    end

    // slave acks after 0..3 wait cycles on the falling edge
    always @(negedge clk) begin
        if (wb_ack) begin
            wb_ack = 1'b0;
            busy   = 1'b0;
        end else if (!wb_stb) begin
            busy = 1'b0;
        end else if (ack_enable) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = int'($urandom % 4);
            end
            if (wait_left == 0) begin
                wb_ack   = 1'b1;
                wb_dat_i = mem[wb_adr[8:3]];
            end else begin
                wait_left--;
            end
        end
    end

    always @(posedge clk) begin
        if (wb_stb && wb_ack && wb_we) begin
            mem[wb_adr[8:3]] = wb_dat_o;
            if (exp_adr.size() == 0) begin
                $display("unexpected store seen on the bus in test %s", test_name);
                errors++;
            end else begin
                checks++;
                assert (wb_adr == exp_adr[0] && wb_dat_o == exp_dat[0]) else begin
                    $display("CHECK FAILED test=%s expected=%h@%h actual=%h@%h", test_name,
                             exp_dat[0], exp_adr[0], wb_dat_o, wb_adr);
                    errors++;
                end
                void'(exp_adr.pop_front());
                void'(exp_dat.pop_front());
            end
        end
    end

    function automatic instr_t r_enc(input logic [6:0] f7, input logic [2:0] f3,
                                     input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
    endfunction

    task automatic send(input instr_t w);
        int t;
        t = 0;
        instr_valid = 1'b1;
        instr       = w;
        #1;
        while (!instr_ready && !hung) begin
            @(negedge clk);
            #1;
            t++;
            if (t > 100) begin
                $display("timeout: instruction never accepted in test %s", test_name);
                errors++;
                hung = 1'b1;
            end
        end
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    // reference model runs each instruction in program order and then issues it
    task automatic run_instr(input int kind, input int rd, input int rs1, input int rs2,
                             input int imm);
        xlen_t  a;
        xlen_t  b;
        xlen_t  iv;
        xlen_t  r;
        xlen_t  adr;
        instr_t w;
        a   = mregs[rs1];
        b   = mregs[rs2];
        iv  = xlen_t'(longint'(imm));
        adr = a + iv;
        r   = '0;
        case (kind)
            K_ADD: begin
                w = r_enc(F7_BASE, F3_ADD_SUB, rd, rs1, rs2);
                r = a + b;
            end
            K_SUB: begin
                w = r_enc(F7_SUB, F3_ADD_SUB, rd, rs1, rs2);
                r = a - b;
            end
            K_AND: begin
                w = r_enc(F7_BASE, F3_AND, rd, rs1, rs2);
                r = a & b;
            end
            K_OR: begin
                w = r_enc(F7_BASE, F3_OR, rd, rs1, rs2);
                r = a | b;
            end
            K_XOR: begin
                w = r_enc(F7_BASE, F3_XOR, rd, rs1, rs2);
                r = a ^ b;
            end
            K_ADDI: begin
                w = {12'(imm), 5'(rs1), F3_ADD_SUB, 5'(rd), OPC_OP_IMM};
                r = a + iv;
            end
            K_LD: begin
                w = {12'(imm), 5'(rs1), F3_DWORD, 5'(rd), OPC_LOAD};
                r = ack_enable ? model_mem[adr[8:3]] : '0; // aborted load gives zero
            end
            default: begin
                w = {7'(imm >> 5), 5'(rs2), 5'(rs1), F3_DWORD, 5'(imm), OPC_STORE};
                exp_adr.push_back(adr);
                exp_dat.push_back(b);
                model_mem[adr[8:3]] = b;
            end
        endcase
        if (kind != K_SD && rd != 0) begin
            mregs[rd] = r;
        end
        send(w);
    endtask

    task automatic nops(input int n);
        repeat (n) run_instr(K_ADDI, 0, 0, 0, 0);
    endtask

    task automatic finish_test(input int err_start);
        int t;
        t = 0;
        while (exp_adr.size() != 0 && !hung) begin
            @(negedge clk);
            t++;
            if (t > 300) begin
                $display("timeout: stores never reached the bus in test %s", test_name);
                errors++;
                hung = 1'b1;
            end
        end
        tests++;
        $display("test %s: %s", test_name, (errors == err_start) ? "ok" : "errors");
    endtask

    initial begin
        int e;
        int t;
        int k;
        void'($urandom(73357));
        for (int i = 0; i < 64; i++) begin
            mem[i]       = 64'h1234_5678_9abc_def0 ^ (xlen_t'(i) * 64'h0101_0101_0101_0101);
            model_mem[i] = mem[i];
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            mregs[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_name = "alu";
        e = errors;
        run_instr(K_ADDI, 1, 0, 0, 1234);
        run_instr(K_ADDI, 2, 0, 0, -77);
        nops(3);
        for (int i = 0; i < 5; i++) begin
            run_instr(i, 3 + i, 1, 2, 0);
        end
        run_instr(K_ADDI, 8, 1, 0, 5);
        nops(3);
        for (int i = 3; i <= 8; i++) begin
            run_instr(K_SD, 0, 0, i, (i - 3) * 8);
        end
        finish_test(e);

        test_name = "forwarding";
        e = errors;
        for (int d = 1; d <= 3; d++) begin
            for (int p = 0; p < 3; p++) begin
                run_instr(K_ADDI, 9, 9, 0, d * 3 + p); // also chains on the old x9
                run_instr(K_ADDI, 9, 9, 0, 100 + p); // younger writer of x9 one stage behind
                nops(d - 1);
                run_instr(K_SUB, 10, (p == 1) ? 2 : 9, (p == 0) ? 2 : 9, 0);
                run_instr(K_SD, 0, 0, 10, 64 + 8 * p);
            end
        end
        run_instr(K_ADDI, 0, 1, 0, 7);
        run_instr(K_ADD, 12, 0, 0, 0);
        run_instr(K_SD, 0, 0, 0, 96);
        run_instr(K_SD, 0, 0, 12, 104);
        finish_test(e);

        test_name = "load_use";
        e = errors;
        for (int i = 0; i < 4; i++) begin
            run_instr(K_SD, 0, 0, 3 + i, 128);
            run_instr(K_LD, 13, 0, 0, 128);
            run_instr(K_ADD, 14, 13, 1, 0);
            run_instr(K_SD, 0, 0, 14, 136);
            run_instr(K_SD, 0, 0, 13, 144);
        end
        finish_test(e);

        test_name = "timeout";
        e = errors;
        ack_enable = 1'b0;
        run_instr(K_LD, 5, 0, 0, 16);
        t = 0;
        while (!bus_error && !hung) begin
            @(negedge clk);
            t++;
            if (t > 40) begin
                $display("timeout: bus_error never rose after a withheld ack");
                errors++;
                hung = 1'b1;
            end
        end
        ack_enable = 1'b1;
        run_instr(K_SD, 0, 0, 5, 152);
        finish_test(e);
        assert (bus_error) else begin
            $display("bus_error did not stay high after the abort");
            errors++;
        end

        test_name = "random";
        e = errors;
        for (int i = 0; i < 200; i++) begin
            k = int'($urandom % 8);
            if (k == K_LD || k == K_SD) begin
                run_instr(k, int'($urandom % 8), 0, int'($urandom % 8), int'($urandom % 64) * 8);
            end else begin
                run_instr(k, int'($urandom % 8), int'($urandom % 8), int'($urandom % 8),
                          int'($urandom % 4096) - 2048);
            end
        end
        for (int i = 1; i < 8; i++) begin
            run_instr(K_SD, 0, 0, i, 200 + 8 * i);
        end
        finish_test(e);

        $display("tests=%0d checks=%0d errors=%0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* rv_pipe_top.f */
rv_pipe_pkg.sv
pipe_ifs.sv
reg_file.sv
id_stage.sv
alu_stage.sv
mem_bus_fsm.sv
bus_timer.sv
rv_pipe_top.sv
rv_pipe_asserts.sv
tb_rv_pipe.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f rv_pipe_top.f --top-module tb_rv_pipe
out=$(./obj_dir/Vtb_rv_pipe)
echo "$out"
if echo "$out" | grep -q "^Simulation passed$"; then
    exit 0
fi
exit 1
